// ==== vlog.f ====
rtl/bridge_pkg.sv
rtl/uart_byte_rx.sv
rtl/uart_byte_tx.sv
rtl/mcu_serial_link.sv
rtl/command_dispatch.sv
rtl/uart_pin_bridge.sv
bench/bridge_clock_gen.sv
bench/bridge_properties.sv
bench/bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module bridge_tb -f vlog.f -o bridge_sim \
  > sim.log 2>&1 && ./obj_dir/bridge_sim >> sim.log 2>&1
cat sim.log
grep -q "=== PASS ===" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== bench/bridge_tb.sv ====
`timescale 1ns/1ps

module bridge_tb;

  localparam int clks_per_bit  = 8;
  localparam int wu_half       = 5;    // sys_clk cycles per WU2 half period
  localparam int wu_period_ns  = 40;
  localparam int wait_limit    = 400;  // sys_clk cycles for any DUT response
  localparam int n_entries     = 14;
  localparam int uart_frame_ns = 10 * clks_per_bit * 4;
  localparam int link_frame_ns = 18 * wu_period_ns;
  localparam int link_reply_ns = 32 * wu_period_ns;  // reply, handshake and idle gap
  localparam int entry_ns      = 2 * uart_frame_ns + link_frame_ns + link_reply_ns;
  localparam int watchdog_ns   = (n_entries + 1) * entry_ns;
  localparam logic [7:0] reply_first = 8'h11;

  typedef struct packed {
    logic       link;   // 0 uart, 1 link frame
    logic [7:0] cmd;
    logic [7:0] dat;    // second uart byte or link dat
    logic       clk_e;
    logic       rst_e;
    logic [7:0] oe_e;
  } entry_t;

  entry_t tbl [n_entries] = '{
    '{1'b0, 8'h10, 8'h00, 1'b1, 1'b0, 8'h00},
    '{1'b0, 8'h12, 8'h00, 1'b1, 1'b1, 8'h00},
    '{1'b0, 8'h11, 8'h00, 1'b0, 1'b1, 8'h00},
    '{1'b0, 8'h13, 8'h00, 1'b0, 1'b0, 8'h00},
    '{1'b0, 8'h33, 8'hA5, 1'b0, 1'b0, 8'h08},
    '{1'b0, 8'h35, 8'h3C, 1'b0, 1'b0, 8'h28},
    '{1'b0, 8'h63, 8'h00, 1'b0, 1'b0, 8'h20},
    '{1'b0, 8'h24, 8'h00, 1'b0, 1'b0, 8'h20},
    '{1'b0, 8'h27, 8'h00, 1'b0, 1'b0, 8'h20},
    '{1'b1, 8'h12, 8'h5E, 1'b0, 1'b1, 8'h20},
    '{1'b1, 8'hB0, 8'hC7, 1'b0, 1'b1, 8'h20},
    '{1'b0, 8'h99, 8'h00, 1'b0, 1'b1, 8'h20},  // unknown opcode
    '{1'b1, 8'h13, 8'h81, 1'b0, 1'b0, 8'h20},
    '{1'b1, 8'hB0, 8'h3A, 1'b0, 1'b0, 8'h20}
  };

  logic                   sys_clk;
  logic                   sys_rst_n;
  logic                   uart_rxd   = 1'b1;
  logic                   cy_A0_INT0 = 1'b0;
  logic                   cy_A3_WU2  = 1'b0;
  bridge_pkg::pin_banks_t in_pins    = '0;
  logic                   uart_txd;
  logic                   cy_A1_INT1;
  bridge_pkg::byte_t      cy_cmd;
  bridge_pkg::byte_t      cy_dat;
  bridge_pkg::byte_t      cy_snd_data0;
  bridge_pkg::byte_t      cy_snd_data1;
  logic                   out_clk;
  logic                   out_rst;
  bridge_pkg::pin_banks_t out_pins;
  logic [7:0]             out_pin_oe;
  logic                   busy;

  bridge_pkg::pin_banks_t exp_pins = '0;  // bank model, updated on pin writes
  integer                 seed     = 32'ha548;
  int                     errors   = 0;
  int                     wu_div   = 0;

  bridge_clock_gen clock_gen_inst (
    .sys_clk  (sys_clk),
    .sys_rst_n(sys_rst_n)
  );

  uart_pin_bridge #(
    .clks_per_bit(clks_per_bit)
  ) uart_pin_bridge_inst (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .uart_rxd    (uart_rxd),
    .uart_txd    (uart_txd),
    .in_pins     (in_pins),
    .cy_A0_INT0  (cy_A0_INT0),
    .cy_A3_WU2   (cy_A3_WU2),
    .cy_A1_INT1  (cy_A1_INT1),
    .cy_cmd      (cy_cmd),
    .cy_dat      (cy_dat),
    .cy_snd_data0(cy_snd_data0),
    .cy_snd_data1(cy_snd_data1),
    .out_clk     (out_clk),
    .out_rst     (out_rst),
    .out_pins    (out_pins),
    .out_pin_oe  (out_pin_oe),
    .busy        (busy)
  );

  // link bit clock, 40 ns
  always @(posedge sys_clk) begin
    if (wu_div == wu_half - 1) begin
      wu_div    <= 0;
      cy_A3_WU2 <= ~cy_A3_WU2;
    end else begin
      wu_div <= wu_div + 1;
    end
  end

  task automatic stop_with_fail();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    stop_with_fail();
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, got);
      stop_with_fail();
    end
  endtask

  task automatic wait_busy(input logic level);
    int waited;
    waited = 0;
    do begin
      @(negedge sys_clk);
      waited++;
      assert (waited <= wait_limit) else abort_run("busy did not reach the expected level");
    end while (busy !== level);
  endtask

  task automatic busy_pulse();
    wait_busy(1'b1);
    wait_busy(1'b0);
  endtask

  task automatic uart_send(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};  // start bit goes first
    repeat (10) begin
      @(posedge sys_clk);
      uart_rxd <= frame[0];
      frame = frame >> 1;
      repeat (clks_per_bit - 1) @(posedge sys_clk);
    end
  endtask

  task automatic uart_receive(output logic [7:0] b, output logic stop_bit);
    int waited;
    waited = 0;
    b = '0;
    do begin
      @(negedge sys_clk);
      waited++;
      assert (waited <= wait_limit) else abort_run("no start bit seen on uart_txd");
    end while (uart_txd);
    repeat (clks_per_bit / 2) @(negedge sys_clk);  // middle of start bit
    repeat (8) begin
      repeat (clks_per_bit) @(negedge sys_clk);
      b = {uart_txd, b[7:1]};
    end
    repeat (clks_per_bit) @(negedge sys_clk);
    stop_bit = uart_txd;
  endtask

  // start bit, then cmd and dat lsb first
  task automatic link_send(input logic [7:0] cmd, input logic [7:0] dat);
    logic [16:0] bits;
    bits = {dat, cmd, 1'b1};
    repeat (17) begin
      @(negedge cy_A3_WU2);
      @(posedge sys_clk);
      cy_A0_INT0 <= bits[0];
      bits = bits >> 1;
    end
    @(negedge cy_A3_WU2);
    @(posedge sys_clk);
    cy_A0_INT0 <= 1'b0;
  endtask

  task automatic link_reply_receive(output logic [15:0] payload, output logic tail);
    int waited;
    waited = 0;
    payload = '0;
    do begin
      @(negedge cy_A3_WU2);
      waited++;
      assert (waited <= 64) else abort_run("no reply marker on cy_A1_INT1");
    end while (!cy_A1_INT1);
    repeat (16) begin
      @(negedge cy_A3_WU2);
      payload = {cy_A1_INT1, payload[15:1]};
    end
    @(negedge cy_A3_WU2);
    tail = cy_A1_INT1;
  endtask

  task automatic run_entry(input entry_t e);
    logic [7:0]  got_byte;
    logic        got_stop;
    logic [15:0] reply;
    logic        tail;
    @(posedge sys_clk);
    in_pins <= {$random(seed), $random(seed)};
    if (e.link && (e.cmd == 8'hB0)) begin
      fork
        link_send(e.cmd, e.dat);
        busy_pulse();
        link_reply_receive(reply, tail);
      join
      check_value("cy_A1_INT1 reply", 64'(reply), 64'({e.dat, reply_first}));
      check_value("cy_A1_INT1 tail", 64'(tail), 64'(0));
      check_value("cy_snd_data0", 64'(cy_snd_data0), 64'(reply_first));
      check_value("cy_snd_data1", 64'(cy_snd_data1), 64'(e.dat));
    end else if (e.link) begin
      fork
        link_send(e.cmd, e.dat);
        busy_pulse();
      join
    end else if (e.cmd[7:4] == 4'h3) begin
      fork
        uart_send(e.cmd);
        wait_busy(1'b1);
      join
      repeat (10 * clks_per_bit) @(posedge sys_clk);  // still waiting for data
      @(negedge sys_clk);
      check_value("busy", 64'(busy), 64'(1));
      fork
        uart_send(e.dat);
        wait_busy(1'b0);
      join
      exp_pins[e.cmd[2:0]] = e.dat;
    end else if (e.cmd[7:4] == 4'h2) begin
      fork
        uart_send(e.cmd);
        busy_pulse();
        uart_receive(got_byte, got_stop);
      join
      check_value("uart_txd data", 64'(got_byte), 64'(in_pins[e.cmd[2:0]]));
      check_value("uart_txd stop bit", 64'(got_stop), 64'(1));
    end else begin
      fork
        uart_send(e.cmd);
        busy_pulse();
      join
    end
    repeat (8) @(negedge cy_A3_WU2);  // let the link handshake settle
    @(negedge sys_clk);
    if (e.link) begin
      check_value("cy_cmd", 64'(cy_cmd), 64'(e.cmd));
      check_value("cy_dat", 64'(cy_dat), 64'(e.dat));
    end
    check_value("out_clk", 64'(out_clk), 64'(e.clk_e));
    check_value("out_rst", 64'(out_rst), 64'(e.rst_e));
    check_value("out_pin_oe", 64'(out_pin_oe), 64'(e.oe_e));
    check_value("out_pins", 64'(out_pins), 64'(exp_pins));
    check_value("busy", 64'(busy), 64'(0));
    check_value("uart_txd", 64'(uart_txd), 64'(1));
  endtask

  initial begin
    @(posedge sys_clk);
    wait (sys_rst_n);
    repeat (4) @(negedge sys_clk);
    check_value("out_clk", 64'(out_clk), 64'(0));
    check_value("out_rst", 64'(out_rst), 64'(0));
    check_value("out_pin_oe", 64'(out_pin_oe), 64'(0));
    check_value("out_pins", 64'(out_pins), 64'(0));
    check_value("busy", 64'(busy), 64'(0));
    check_value("cy_A1_INT1", 64'(cy_A1_INT1), 64'(0));
    check_value("uart_txd", 64'(uart_txd), 64'(1));
    foreach (tbl[n]) begin
      run_entry(tbl[n]);
    end
    if (errors == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_with_fail();
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the table was finished");
    stop_with_fail();
  end

endmodule

// ==== bench/bridge_properties.sv ====
`timescale 1ns/1ps

module bridge_properties (
  input logic       sys_clk,
  input logic       sys_rst_n,
  input logic       busy,
  input logic       uart_txd,
  input logic       snd_req,
  input logic       snd_ack,
  input logic [7:0] out_pin_oe
);

  // oe bits only move while a command executes
  oe_only_when_busy: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
      (out_pin_oe != $past(out_pin_oe)) |-> $past(busy)
  ) else $error("out_pin_oe changed without a pending command");

  snd_req_held_until_ack: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
      $fell(snd_req) |-> $past(snd_ack)
  ) else $error("snd_req fell before snd_ack was high");

  txd_idle_in_reset: assert property (
    @(posedge sys_clk) !sys_rst_n |-> uart_txd
  ) else $error("uart_txd low while in reset");

endmodule

bind uart_pin_bridge bridge_properties bridge_properties_inst (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .busy      (busy),
  .uart_txd  (uart_txd),
  .snd_req   (snd_req),
  .snd_ack   (snd_ack),
  .out_pin_oe(out_pin_oe)
);

// ==== bench/bridge_clock_gen.sv ====
`timescale 1ns/1ps

module bridge_clock_gen (
  output logic sys_clk,
  output logic sys_rst_n
);

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;  // 4 ns period
  end

  initial begin
    sys_rst_n = 1'b1;
    #1 sys_rst_n = 1'b0;  // a real falling edge, so the async resets fire
    repeat (8) @(posedge sys_clk);
    sys_rst_n <= 1'b1;
  end

endmodule

// ==== rtl/uart_pin_bridge.sv ====
`timescale 1ns/1ps

module uart_pin_bridge #(
  parameter int clks_per_bit = 434
) (
  input  logic                              sys_clk,
  input  logic                              sys_rst_n,
  input  logic                              uart_rxd,
  output logic                              uart_txd,
  input  bridge_pkg::pin_banks_t            in_pins,
  input  logic                              cy_A0_INT0,  // link data
  input  logic                              cy_A3_WU2,   // link bit clock
  output logic                              cy_A1_INT1,
  output bridge_pkg::byte_t                 cy_cmd,
  output bridge_pkg::byte_t                 cy_dat,
  output bridge_pkg::byte_t                 cy_snd_data0,
  output bridge_pkg::byte_t                 cy_snd_data1,
  output logic                              out_clk,
  output logic                              out_rst,
  output bridge_pkg::pin_banks_t            out_pins,
  output logic [bridge_pkg::bank_count-1:0] out_pin_oe,
  output logic                              busy
);

  bridge_pkg::byte_t rx_data;
  bridge_pkg::byte_t tx_data;
  logic              rx_valid;
  logic              tx_send;
  logic              rec_req;
  logic              rec_ack;
  logic              snd_req;
  logic              snd_ack;

  uart_byte_rx #(
    .clks_per_bit(clks_per_bit)
  ) uart_byte_rx_inst (
    .sys_clk  (sys_clk),
    .sys_rst_n(sys_rst_n),
    .uart_rxd (uart_rxd),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  uart_byte_tx #(
    .clks_per_bit(clks_per_bit)
  ) uart_byte_tx_inst (
    .sys_clk  (sys_clk),
    .sys_rst_n(sys_rst_n),
    .tx_send  (tx_send),
    .tx_data  (tx_data),
    .uart_txd (uart_txd)
  );

  mcu_serial_link mcu_serial_link_inst (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .cy_A3_WU2   (cy_A3_WU2),
    .cy_A0_INT0  (cy_A0_INT0),
    .rec_ack     (rec_ack),
    .snd_req     (snd_req),
    .cy_snd_data0(cy_snd_data0),
    .cy_snd_data1(cy_snd_data1),
    .cy_cmd      (cy_cmd),
    .cy_dat      (cy_dat),
    .rec_req     (rec_req),
    .snd_ack     (snd_ack),
    .cy_A1_INT1  (cy_A1_INT1)
  );

  command_dispatch command_dispatch_inst (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .rx_data     (rx_data),
    .rx_valid    (rx_valid),
    .in_pins     (in_pins),
    .rec_req     (rec_req),
    .cy_cmd      (cy_cmd),
    .cy_dat      (cy_dat),
    .snd_ack     (snd_ack),
    .tx_send     (tx_send),
    .tx_data     (tx_data),
    .rec_ack     (rec_ack),
    .snd_req     (snd_req),
    .cy_snd_data0(cy_snd_data0),
    .cy_snd_data1(cy_snd_data1),
    .out_clk     (out_clk),
    .out_rst     (out_rst),
    .out_pins    (out_pins),
    .out_pin_oe  (out_pin_oe),
    .busy        (busy)
  );

endmodule

// ==== rtl/command_dispatch.sv ====
`timescale 1ns/1ps

module command_dispatch (
  input  logic                              sys_clk,
  input  logic                              sys_rst_n,
  input  bridge_pkg::byte_t                 rx_data,
  input  logic                              rx_valid,
  input  bridge_pkg::pin_banks_t            in_pins,
  input  logic                              rec_req,
  input  bridge_pkg::byte_t                 cy_cmd,
  input  bridge_pkg::byte_t                 cy_dat,
  input  logic                              snd_ack,
  output logic                              tx_send,
  output bridge_pkg::byte_t                 tx_data,
  output logic                              rec_ack,
  output logic                              snd_req,
  output bridge_pkg::byte_t                 cy_snd_data0,
  output bridge_pkg::byte_t                 cy_snd_data1,
  output logic                              out_clk,
  output logic                              out_rst,
  output bridge_pkg::pin_banks_t            out_pins,
  output logic [bridge_pkg::bank_count-1:0] out_pin_oe,
  output logic                              busy
);

  bridge_pkg::byte_t     command;    // 0 means idle
  bridge_pkg::byte_t     data;
  logic                  data_arrive;
  logic                  done;
  bridge_pkg::op_group_t op;
  bridge_pkg::bank_idx_t bank;
  bridge_pkg::ctrl_sub_t sub;
  logic                  bank_op_ok;
  logic                  exec_now;
  logic                  start_read;
  logic                  start_reply;

  assign op         = bridge_pkg::op_group_t'(command[7:4]);
  assign bank       = command[2:0];
  assign sub        = bridge_pkg::ctrl_sub_t'(command[1:0]);
  assign bank_op_ok = !command[3];  // x8..xF name no bank
  assign exec_now   = (command != 8'h00) && !done;
  assign start_read = exec_now && (op == bridge_pkg::op_pin_read) && bank_op_ok;

  // a new reply waits until the previous snd handshake is closed
  assign start_reply = exec_now && (op == bridge_pkg::op_mcu_reply) &&
                       (command[3:0] == 4'h0) && !snd_req && !snd_ack;

  assign busy = (command != 8'h00);

  // command latch and rec handshake
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      command     <= '0;
      data_arrive <= 1'b0;
      rec_ack     <= 1'b0;
    end else begin
      data_arrive <= 1'b0;
      if (rec_ack && !rec_req) rec_ack <= 1'b0;
      if (done) begin
        command <= '0;
      end else if (command == 8'h00) begin
        if (rx_valid) begin
          command <= rx_data;  // uart wins over the link
        end else if (rec_req && !rec_ack) begin
          command <= cy_cmd;
          rec_ack <= 1'b1;
        end
      end else if (rx_valid) begin
        data_arrive <= 1'b1;   // second byte of a pending command
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rx_valid && (command != 8'h00) && !done) data <= rx_data;
    if (start_read) tx_data <= in_pins[bank];
    if (start_reply) begin
      cy_snd_data0 <= bridge_pkg::reply_tag;
      cy_snd_data1 <= cy_dat;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      done       <= 1'b0;
      tx_send    <= 1'b0;
      snd_req    <= 1'b0;
      out_clk    <= 1'b0;
      out_rst    <= 1'b0;
      out_pins   <= '0;
      out_pin_oe <= '0;
    end else begin
      tx_send <= start_read;  // one cycle pulse
      if (start_reply) snd_req <= 1'b1;
      else if (snd_ack) snd_req <= 1'b0;

      if (done) begin
        done <= 1'b0;         // clears together with command
      end else if (exec_now) begin
        done <= 1'b1;         // most opcodes finish at once
        case (op)
          bridge_pkg::op_ctrl: begin
            if (command[3:2] == 2'b00) begin
              case (sub)
                bridge_pkg::clk_set:   out_clk <= 1'b1;
                bridge_pkg::clk_clear: out_clk <= 1'b0;
                bridge_pkg::rst_set:   out_rst <= 1'b1;
                bridge_pkg::rst_clear: out_rst <= 1'b0;
              endcase
            end
          end
          bridge_pkg::op_pin_write: begin
            if (bank_op_ok) begin
              if (data_arrive) begin
                out_pins[bank]   <= data;
                out_pin_oe[bank] <= 1'b1;
              end else begin
                done <= 1'b0;  // still waiting for the data byte
              end
            end
          end
          bridge_pkg::op_pin_release: begin
            if (bank_op_ok) out_pin_oe[bank] <= 1'b0;
          end
          bridge_pkg::op_mcu_reply: begin
            done <= start_reply || (command[3:0] != 4'h0);
          end
          default: begin
            // pin read goes via start_read, unknown codes just finish
          end
        endcase
      end
    end
  end

endmodule

// ==== rtl/mcu_serial_link.sv ====
`timescale 1ns/1ps

module mcu_serial_link (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              cy_A3_WU2,
  input  logic              cy_A0_INT0,
  input  logic              rec_ack,
  input  logic              snd_req,
  input  bridge_pkg::byte_t cy_snd_data0,
  input  bridge_pkg::byte_t cy_snd_data1,
  output bridge_pkg::byte_t cy_cmd,
  output bridge_pkg::byte_t cy_dat,
  output logic              rec_req,
  output logic              snd_ack,
  output logic              cy_A1_INT1
);

  localparam int rec_cnt_w = $clog2(bridge_pkg::frame_bits);
  localparam int snd_last  = bridge_pkg::frame_bits + 2;  // marker, payload, trailing 0
  localparam int snd_cnt_w = $clog2(snd_last + 1);

  bridge_pkg::link_state_t           state;
  logic [rec_cnt_w-1:0]              rec_cnt;
  logic [snd_cnt_w-1:0]              snd_cnt;
  logic [bridge_pkg::frame_bits-1:0] reply_sr;
  logic                              rec_req_w;
  logic                              snd_ack_w;
  logic                              rec_ack_w;
  logic                              snd_req_w;
  logic [1:0]                        wu_s1;   // {snd_req, rec_ack}
  logic [1:0]                        wu_s2;
  logic [1:0]                        sys_s1;  // {snd_ack, rec_req}
  logic [1:0]                        sys_s2;

  // levels from sys_clk into the wake clock
  always_ff @(posedge cy_A3_WU2 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wu_s1 <= '0;
      wu_s2 <= '0;
    end else begin
      wu_s1 <= {snd_req, rec_ack};
      wu_s2 <= wu_s1;
    end
  end

  assign snd_req_w = wu_s2[1];
  assign rec_ack_w = wu_s2[0];

  // and back the other way
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      sys_s1 <= '0;
      sys_s2 <= '0;
    end else begin
      sys_s1 <= {snd_ack_w, rec_req_w};
      sys_s2 <= sys_s1;
    end
  end

  assign snd_ack = sys_s2[1];
  assign rec_req = sys_s2[0];

  always_ff @(posedge cy_A3_WU2 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state     <= bridge_pkg::idle;
      rec_cnt   <= '0;
      rec_req_w <= 1'b0;
      cy_cmd    <= '0;
      cy_dat    <= '0;
    end else begin
      case (state)
        bridge_pkg::idle: begin
          rec_cnt <= '0;
          // old ack must be gone, else a new req would be dropped at once
          if (cy_A0_INT0 && !rec_ack_w) state <= bridge_pkg::shift_cmd;
        end
        bridge_pkg::shift_cmd: begin
          cy_cmd  <= {cy_A0_INT0, cy_cmd[7:1]};  // lsb first
          rec_cnt <= rec_cnt + 1'b1;
          if (rec_cnt == rec_cnt_w'(bridge_pkg::frame_bits / 2 - 1)) begin
            state <= bridge_pkg::shift_dat;
          end
        end
        bridge_pkg::shift_dat: begin
          cy_dat  <= {cy_A0_INT0, cy_dat[7:1]};
          rec_cnt <= rec_cnt + 1'b1;
          if (rec_cnt == rec_cnt_w'(bridge_pkg::frame_bits - 1)) begin
            rec_req_w <= 1'b1;
            state     <= bridge_pkg::hold_req;
          end
        end
        bridge_pkg::hold_req: begin
          if (rec_ack_w) begin
            rec_req_w <= 1'b0;
            state     <= bridge_pkg::idle;
          end
        end
        default: state <= bridge_pkg::idle;
      endcase
    end
  end

  // reply: 1, data0, data1, 0, then ack until req drops
  always_ff @(posedge cy_A3_WU2 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      snd_cnt    <= '0;
      snd_ack_w  <= 1'b0;
      cy_A1_INT1 <= 1'b0;
    end else if (!snd_req_w) begin
      snd_cnt   <= '0;
      snd_ack_w <= 1'b0;
    end else if (snd_cnt == snd_cnt_w'(snd_last)) begin
      snd_ack_w <= 1'b1;
    end else begin
      snd_cnt <= snd_cnt + 1'b1;
      if (snd_cnt == '0) begin
        cy_A1_INT1 <= 1'b1;  // start marker
      end else if (snd_cnt == snd_cnt_w'(snd_last - 1)) begin
        cy_A1_INT1 <= 1'b0;
      end else begin
        cy_A1_INT1 <= reply_sr[0];
      end
    end
  end

  always_ff @(posedge cy_A3_WU2) begin
    if (snd_req_w && (snd_cnt == '0)) begin
      reply_sr <= {cy_snd_data1, cy_snd_data0};  // stable while snd_req is high
    end else if (snd_req_w) begin
      reply_sr <= reply_sr >> 1;
    end
  end

endmodule

// ==== rtl/uart_byte_tx.sv ====
`timescale 1ns/1ps

module uart_byte_tx #(
  parameter int clks_per_bit = 434
) (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              tx_send,
  input  bridge_pkg::byte_t tx_data,
  output logic              uart_txd
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);

  logic [9:0]       frame;      // stop, data, start with bit 0 on the line
  logic [3:0]       bits_left;
  logic [cnt_w-1:0] cnt;
  logic             active;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      frame     <= '1;
      bits_left <= '0;
      cnt       <= '0;
      active    <= 1'b0;
    end else if (!active) begin
      // a send pulse during a frame is simply lost
      if (tx_send) begin
        frame     <= {1'b1, tx_data, 1'b0};
        bits_left <= 4'd10;
        cnt       <= '0;
        active    <= 1'b1;
      end
    end else if (cnt == full_cnt) begin
      cnt       <= '0;
      frame     <= {1'b1, frame[9:1]};  // shift in idle level
      bits_left <= bits_left - 1'b1;
      if (bits_left == 4'd1) active <= 1'b0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign uart_txd = frame[0];

endmodule

// ==== rtl/uart_byte_rx.sv ====
`timescale 1ns/1ps

module uart_byte_rx #(
  parameter int clks_per_bit = 434
) (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              uart_rxd,
  output bridge_pkg::byte_t rx_data,
  output logic              rx_valid
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_bits,
    st_stop
  } rx_state_t;

  rx_state_t         state;
  logic [1:0]        rxd_sync;
  logic [cnt_w-1:0]  cnt;
  logic [2:0]        bit_idx;
  bridge_pkg::byte_t shift;
  logic              sample_bit;
  logic              stop_ok;

  assign sample_bit = (state == st_bits) && (cnt == full_cnt);
  assign stop_ok    = (state == st_stop) && (cnt == full_cnt) && rxd_sync[1];

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rxd_sync <= 2'b11;  // idle line is high
      state    <= st_idle;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rxd_sync <= {rxd_sync[0], uart_rxd};
      rx_valid <= stop_ok;
      case (state)
        st_idle: begin
          cnt     <= '0;
          bit_idx <= '0;
          if (!rxd_sync[1]) state <= st_start;
        end
        st_start: begin
          // recheck the start bit at its middle
          if (cnt == half_cnt) begin
            cnt   <= '0;
            state <= rxd_sync[1] ? st_idle : st_bits;  // glitch, back to idle
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_bits: begin
          if (sample_bit) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= st_stop;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_stop: begin
          // low stop bit drops the frame
          if (cnt == full_cnt) state <= st_idle;
          else cnt <= cnt + 1'b1;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sample_bit) shift <= {rxd_sync[1], shift[7:1]};  // lsb first
    if (stop_ok) rx_data <= shift;
  end

endmodule

// ==== rtl/bridge_pkg.sv ====
package bridge_pkg;

  typedef logic [7:0] byte_t;  // data, command or pin bank

  localparam int bank_count = 8;

  typedef logic [2:0] bank_idx_t;

  // eight banks of one byte, bank n at [n]
  typedef logic [bank_count-1:0][7:0] pin_banks_t;

  // upper nibble of a command byte
  typedef enum logic [3:0] {
    op_none        = 4'h0,
    op_ctrl        = 4'h1,
    op_pin_read    = 4'h2,
    op_pin_write   = 4'h3,
    op_pin_release = 4'h6,
    op_mcu_reply   = 4'hB
  } op_group_t;

  // low bits of the control opcodes 0x10..0x13
  typedef enum logic [1:0] {
    clk_set   = 2'd0,
    clk_clear = 2'd1,
    rst_set   = 2'd2,
    rst_clear = 2'd3
  } ctrl_sub_t;

  // receive side of the wake clock link
  typedef enum logic [1:0] {
    idle      = 2'd0,
    shift_cmd = 2'd1,
    shift_dat = 2'd2,
    hold_req  = 2'd3
  } link_state_t;

  localparam int frame_bits = 16;  // cmd byte then dat byte

  localparam byte_t reply_tag = 8'h11;

endpackage
